/* run.sh */
#!/bin/sh
# build and run the ooo_core testbench with Verilator
rm -f sim.log
verilator --binary --timing --top-module tb_ooo_core -f src.f -o tb_sim > build.log 2>&1 &&
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "SIMULATION PASSED" sim.log && echo "run passed" ||
{ echo "run failed, see build.log and sim.log"; exit 1; }

/* src.f */
src/isa_pkg.sv
src/uarch_pkg.sv
src/issue_stage.sv
src/map_table.sv
src/reorder_buffer.sv
src/reservation_station.sv
src/alu_unit.sv
src/ooo_core.sv
verif/tb_ooo_core.sv

/* src/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit import isa_pkg::*; #(
	parameter int rob_depth = 8
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          dispatch_valid,
	input  alu_op_e                       dispatch_op,
	input  logic [xlen-1:0]               dispatch_a,
	input  logic [xlen-1:0]               dispatch_b,
	input  logic [$clog2(rob_depth)-1:0]  dispatch_tag,
	output logic                          bus_valid,
	output logic [$clog2(rob_depth)-1:0]  bus_tag,
	output logic [xlen-1:0]               bus_value
);

	logic [xlen-1:0] result;

	always_comb begin
		case (dispatch_op)
			op_add, op_addi: result = dispatch_a + dispatch_b;
			op_sub:  result = dispatch_a - dispatch_b;
			op_and:  result = dispatch_a & dispatch_b;
			op_or:   result = dispatch_a | dispatch_b;
			op_xor:  result = dispatch_a ^ dispatch_b;
			op_slt:  result = {{(xlen - 1){1'b0}}, $signed(dispatch_a) < $signed(dispatch_b)};
			op_sll:  result = dispatch_a << dispatch_b[4:0];
			default: result = '0;
		endcase
	end

	// result bus, one cycle per dispatch
	always_ff @(posedge clock) begin
		if (reset) begin
			bus_valid <= 1'b0;
		end else begin
			bus_valid <= dispatch_valid;
		end
	end

	always_ff @(posedge clock) begin
		bus_tag <= dispatch_tag;
		bus_value <= result;
	end

endmodule

/* src/isa_pkg.sv */
package isa_pkg;

	//////////////////////////////
	// architectural widths
	//////////////////////////////

	// data path width
	parameter int xlen = 32;
	// 32 architectural registers, r0 hardwired to zero
	parameter int reg_idx_w = 5;

	//////////////////////////////
	// alu opcodes
	//////////////////////////////

	typedef enum logic [2:0] {
		op_add  = 3'd0,
		op_sub  = 3'd1,
		op_and  = 3'd2,
		op_or   = 3'd3,
		op_xor  = 3'd4,
		op_slt  = 3'd5,  // signed compare
		op_sll  = 3'd6,  // shift by b[4:0]
		op_addi = 3'd7   // b is the immediate
	} alu_op_e;

endpackage

/* src/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage import isa_pkg::*, uarch_pkg::*; #(
	parameter int rob_depth = 8
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          inst_valid,
	input  alu_op_e                       inst_op,
	input  logic [reg_idx_w-1:0]          inst_rd,
	input  logic [reg_idx_w-1:0]          inst_rs1,
	input  logic [reg_idx_w-1:0]          inst_rs2,
	input  logic [xlen-1:0]               inst_imm,
	input  logic                          rob_full,
	input  logic                          rs_full,
	input  logic                          map_busy_a,
	input  logic                          map_busy_b,
	input  logic [$clog2(rob_depth)-1:0]  map_tag_a,
	input  logic [$clog2(rob_depth)-1:0]  map_tag_b,
	input  logic                          read_done_a,
	input  logic                          read_done_b,
	input  logic [xlen-1:0]               read_val_a,
	input  logic [xlen-1:0]               read_val_b,
	input  logic                          bus_valid,
	input  logic [$clog2(rob_depth)-1:0]  bus_tag,
	input  logic [xlen-1:0]               bus_value,
	input  logic                          retire_valid,
	input  logic [reg_idx_w-1:0]          retire_rd,
	input  logic [xlen-1:0]               retire_value,
	output logic                          issue_stall,
	output logic                          alloc_en,
	output alu_op_e                       alloc_op,
	output logic [reg_idx_w-1:0]          alloc_rd,
	output logic [xlen-1:0]               opnd_a,
	output logic [xlen-1:0]               opnd_b,
	output logic [$clog2(rob_depth)-1:0]  opnd_tag_a,
	output logic [$clog2(rob_depth)-1:0]  opnd_tag_b,
	output opnd_src_e                     opnd_src_a,
	output opnd_src_e                     opnd_src_b,
	output logic [$clog2(rob_depth)-1:0]  read_tag_a,
	output logic [$clog2(rob_depth)-1:0]  read_tag_b
);

	localparam int tag_w = $clog2(rob_depth);
	localparam int num_regs = 1 << reg_idx_w;

	logic [xlen-1:0] regs [num_regs];
	logic [xlen-1:0] rf_a;
	logic [xlen-1:0] rf_b;

	// not renamed -> regfile, finished in rob -> rob, else wait on bus
	function automatic opnd_src_e pick_src(input logic busy, input logic done);
		if (!busy)
			return src_regfile;
		else if (done)
			return src_rob;
		return src_bus;
	endfunction

	function automatic logic [xlen-1:0] pick_val(
		input opnd_src_e        src,
		input logic [xlen-1:0]  rf_val,
		input logic [xlen-1:0]  rob_val,
		input logic [tag_w-1:0] tag
	);
		case (src)
			src_regfile: return rf_val;
			src_rob:     return rob_val;
			// producer broadcasting right now
			default:     return (bus_valid && bus_tag == tag) ? bus_value : '0;
		endcase
	endfunction

	//////////////////////////////
	// stall and allocation
	//////////////////////////////

	assign issue_stall = rob_full || rs_full;
	assign alloc_en = inst_valid && !issue_stall;
	assign alloc_op = inst_op;
	assign alloc_rd = inst_rd;

	// rob lookup follows the map table
	assign read_tag_a = map_tag_a;
	assign read_tag_b = map_tag_b;

	//////////////////////////////
	// register file
	//////////////////////////////

	// bypass a retiring write, r0 stays zero
	assign rf_a = (retire_valid && retire_rd == inst_rs1 && inst_rs1 != '0) ?
		retire_value : regs[inst_rs1];
	assign rf_b = (retire_valid && retire_rd == inst_rs2 && inst_rs2 != '0) ?
		retire_value : regs[inst_rs2];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (retire_valid && retire_rd != '0) begin
			regs[retire_rd] <= retire_value;
		end
	end

	//////////////////////////////
	// operand select
	//////////////////////////////

	always_comb begin
		opnd_src_a = pick_src(map_busy_a, read_done_a);
		opnd_a = pick_val(opnd_src_a, rf_a, read_val_a, map_tag_a);
		opnd_tag_a = map_tag_a;
		// addi takes the immediate, always ready
		if (inst_op == op_addi) begin
			opnd_src_b = src_regfile;
			opnd_b = inst_imm;
		end else begin
			opnd_src_b = pick_src(map_busy_b, read_done_b);
			opnd_b = pick_val(opnd_src_b, rf_b, read_val_b, map_tag_b);
		end
		opnd_tag_b = map_tag_b;
	end

endmodule

/* src/map_table.sv */
`timescale 1ns/1ps

module map_table import isa_pkg::*; #(
	parameter int rob_depth = 8
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          alloc_en,
	input  logic [reg_idx_w-1:0]          alloc_rd,
	input  logic [$clog2(rob_depth)-1:0]  alloc_tag,
	input  logic [reg_idx_w-1:0]          inst_rs1,
	input  logic [reg_idx_w-1:0]          inst_rs2,
	input  logic                          retire_valid,
	input  logic [reg_idx_w-1:0]          retire_rd,
	input  logic [$clog2(rob_depth)-1:0]  retire_tag,
	output logic                          map_busy_a,
	output logic                          map_busy_b,
	output logic [$clog2(rob_depth)-1:0]  map_tag_a,
	output logic [$clog2(rob_depth)-1:0]  map_tag_b
);

	localparam int tag_w = $clog2(rob_depth);
	localparam int num_regs = 1 << reg_idx_w;

	// busy bit per register plus the producing rob tag
	logic             busy [num_regs];
	logic [tag_w-1:0] tags [num_regs];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < num_regs; i++) begin
				busy[i] <= 1'b0;
			end
		end else begin
			// clear only if no younger rename replaced it
			if (retire_valid && busy[retire_rd] && tags[retire_rd] == retire_tag) begin
				busy[retire_rd] <= 1'b0;
			end
			// new rename wins over a same-edge clear
			if (alloc_en && alloc_rd != '0) begin
				busy[alloc_rd] <= 1'b1;
				tags[alloc_rd] <= alloc_tag;
			end
		end
	end

	// source lookups for the instruction at issue
	assign map_busy_a = busy[inst_rs1];
	assign map_busy_b = busy[inst_rs2];
	assign map_tag_a = tags[inst_rs1];
	assign map_tag_b = tags[inst_rs2];

endmodule

/* src/ooo_core.sv */
`timescale 1ns/1ps

module ooo_core import isa_pkg::*, uarch_pkg::*; #(
	parameter int rob_depth = 8,
	parameter int rs_depth = 4
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  inst_valid,
	input  alu_op_e               inst_op,
	input  logic [reg_idx_w-1:0]  inst_rd,
	input  logic [reg_idx_w-1:0]  inst_rs1,
	input  logic [reg_idx_w-1:0]  inst_rs2,
	input  logic [xlen-1:0]       inst_imm,
	output logic                  issue_stall,
	output logic                  commit_valid,
	output logic [reg_idx_w-1:0]  commit_rd,
	output logic [xlen-1:0]       commit_data
);

	localparam int tag_w = $clog2(rob_depth);

	// issue to rob, map table and station
	logic alloc_en;
	alu_op_e alloc_op;
	logic [reg_idx_w-1:0] alloc_rd;
	logic [xlen-1:0] opnd_a, opnd_b;
	logic [tag_w-1:0] opnd_tag_a, opnd_tag_b;
	opnd_src_e opnd_src_a, opnd_src_b;
	logic [tag_w-1:0] read_tag_a, read_tag_b;
	// rob and map answers
	logic rob_full, rs_full;
	logic [tag_w-1:0] alloc_tag;
	logic read_done_a, read_done_b;
	logic [xlen-1:0] read_val_a, read_val_b;
	logic map_busy_a, map_busy_b;
	logic [tag_w-1:0] map_tag_a, map_tag_b;
	// execute and result bus
	logic dispatch_valid;
	alu_op_e dispatch_op;
	logic [xlen-1:0] dispatch_a, dispatch_b;
	logic [tag_w-1:0] dispatch_tag;
	logic bus_valid;
	logic [tag_w-1:0] bus_tag;
	logic [xlen-1:0] bus_value;
	// retire
	logic retire_valid;
	logic [reg_idx_w-1:0] retire_rd;
	logic [tag_w-1:0] retire_tag;
	logic [xlen-1:0] retire_value;

	assign commit_valid = retire_valid;
	assign commit_rd = retire_rd;
	assign commit_data = retire_value;

	issue_stage #(.rob_depth(rob_depth)) u_issue (.*);

	map_table #(.rob_depth(rob_depth)) u_map (.*);

	reorder_buffer #(.rob_depth(rob_depth)) u_rob (.*);

	reservation_station #(.rob_depth(rob_depth), .rs_depth(rs_depth)) u_rs (.*);

	alu_unit #(.rob_depth(rob_depth)) u_alu (.*);

endmodule

/* src/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer import isa_pkg::*, uarch_pkg::*; #(
	parameter int rob_depth = 8
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          alloc_en,
	input  logic [reg_idx_w-1:0]          alloc_rd,
	input  logic                          bus_valid,
	input  logic [$clog2(rob_depth)-1:0]  bus_tag,
	input  logic [xlen-1:0]               bus_value,
	input  logic [$clog2(rob_depth)-1:0]  read_tag_a,
	input  logic [$clog2(rob_depth)-1:0]  read_tag_b,
	output logic                          rob_full,
	output logic [$clog2(rob_depth)-1:0]  alloc_tag,
	output logic                          read_done_a,
	output logic                          read_done_b,
	output logic [xlen-1:0]               read_val_a,
	output logic [xlen-1:0]               read_val_b,
	output logic                          retire_valid,
	output logic [reg_idx_w-1:0]          retire_rd,
	output logic [$clog2(rob_depth)-1:0]  retire_tag,
	output logic [xlen-1:0]               retire_value
);

	localparam int tag_w = $clog2(rob_depth);

	rob_state_e           state [rob_depth];
	logic [reg_idx_w-1:0] dest  [rob_depth];
	logic [xlen-1:0]      value [rob_depth];

	logic [tag_w-1:0] head;
	logic [tag_w-1:0] tail;
	logic [tag_w:0]   count;
	logic             retire_fire;
	logic             hit_a;
	logic             hit_b;

	function automatic logic [tag_w-1:0] next_ptr(input logic [tag_w-1:0] ptr);
		return (ptr == tag_w'(rob_depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign rob_full = (count == (tag_w + 1)'(rob_depth));
	assign alloc_tag = tail;
	// in-order retire once the head is finished
	assign retire_fire = (state[head] == rob_done);

	//////////////////////////////
	// operand read ports
	//////////////////////////////

	// the retiring entry is already freed but the map still points at it
	assign hit_a = retire_valid && retire_tag == read_tag_a;
	assign hit_b = retire_valid && retire_tag == read_tag_b;
	assign read_done_a = hit_a || state[read_tag_a] == rob_done;
	assign read_done_b = hit_b || state[read_tag_b] == rob_done;
	// its value stays in place until the slot is written again
	assign read_val_a = value[read_tag_a];
	assign read_val_b = value[read_tag_b];

	//////////////////////////////
	// pointers and entry state
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			retire_valid <= 1'b0;
			for (int i = 0; i < rob_depth; i++) begin
				state[i] <= rob_empty;
			end
		end else begin
			// result bus completes an entry
			if (bus_valid) begin
				state[bus_tag] <= rob_done;
			end
			if (retire_fire) begin
				state[head] <= rob_empty;
				head <= next_ptr(head);
			end
			if (alloc_en) begin
				state[tail] <= rob_busy;
				tail <= next_ptr(tail);
			end
			count <= count + (tag_w + 1)'(alloc_en) - (tag_w + 1)'(retire_fire);
			retire_valid <= retire_fire;
		end
	end

	// payload is meaningful only with state
	always_ff @(posedge clock) begin
		if (bus_valid) begin
			value[bus_tag] <= bus_value;
		end
		if (alloc_en) begin
			dest[tail] <= alloc_rd;
		end
		retire_rd <= dest[head];
		retire_tag <= head;
		retire_value <= value[head];
	end

endmodule

/* src/reservation_station.sv */
`timescale 1ns/1ps

module reservation_station import isa_pkg::*, uarch_pkg::*; #(
	parameter int rob_depth = 8,
	parameter int rs_depth = 4
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          alloc_en,
	input  alu_op_e                       alloc_op,
	input  logic [$clog2(rob_depth)-1:0]  alloc_tag,
	input  logic [xlen-1:0]               opnd_a,
	input  logic [xlen-1:0]               opnd_b,
	input  logic [$clog2(rob_depth)-1:0]  opnd_tag_a,
	input  logic [$clog2(rob_depth)-1:0]  opnd_tag_b,
	input  opnd_src_e                     opnd_src_a,
	input  opnd_src_e                     opnd_src_b,
	input  logic                          bus_valid,
	input  logic [$clog2(rob_depth)-1:0]  bus_tag,
	input  logic [xlen-1:0]               bus_value,
	output logic                          rs_full,
	output logic                          dispatch_valid,
	output alu_op_e                       dispatch_op,
	output logic [xlen-1:0]               dispatch_a,
	output logic [xlen-1:0]               dispatch_b,
	output logic [$clog2(rob_depth)-1:0]  dispatch_tag
);

	localparam int tag_w = $clog2(rob_depth);
	// age = number of younger valid entries, never above rs_depth-1
	localparam int age_w = (rs_depth > 1) ? $clog2(rs_depth) : 1;

	logic             valid  [rs_depth];
	alu_op_e          op     [rs_depth];
	logic [tag_w-1:0] dest   [rs_depth];
	logic [xlen-1:0]  val_a  [rs_depth];
	logic [xlen-1:0]  val_b  [rs_depth];
	logic [tag_w-1:0] wait_a [rs_depth];
	logic [tag_w-1:0] wait_b [rs_depth];
	logic             rdy_a  [rs_depth];
	logic             rdy_b  [rs_depth];
	logic [age_w-1:0] age    [rs_depth];

	logic [age_w-1:0] free_idx;
	logic [age_w-1:0] sel_idx;
	logic             free_found;
	logic             sel_found;
	logic             do_alloc;

	//////////////////////////////
	// free slot and oldest ready
	//////////////////////////////

	// lowest free index
	always_comb begin
		free_idx = '0;
		free_found = 1'b0;
		for (int i = rs_depth - 1; i >= 0; i--) begin
			if (!valid[i]) begin
				free_idx = age_w'(i);
				free_found = 1'b1;
			end
		end
	end

	// highest age among ready entries
	always_comb begin
		sel_idx = '0;
		sel_found = 1'b0;
		for (int i = 0; i < rs_depth; i++) begin
			if (valid[i] && rdy_a[i] && rdy_b[i] && (!sel_found || age[i] > age[sel_idx])) begin
				sel_idx = age_w'(i);
				sel_found = 1'b1;
			end
		end
	end

	assign rs_full = !free_found;
	assign do_alloc = alloc_en && free_found;

	assign dispatch_valid = sel_found;
	assign dispatch_op = op[sel_idx];
	assign dispatch_a = val_a[sel_idx];
	assign dispatch_b = val_b[sel_idx];
	assign dispatch_tag = dest[sel_idx];

	//////////////////////////////
	// wake-up, ageing, alloc
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < rs_depth; i++) begin
				valid[i] <= 1'b0;
				age[i] <= '0;
			end
		end else begin
			for (int i = 0; i < rs_depth; i++) begin
				// snoop the result bus
				if (valid[i] && !rdy_a[i] && bus_valid && bus_tag == wait_a[i]) begin
					rdy_a[i] <= 1'b1;
					val_a[i] <= bus_value;
				end
				if (valid[i] && !rdy_b[i] && bus_valid && bus_tag == wait_b[i]) begin
					rdy_b[i] <= 1'b1;
					val_b[i] <= bus_value;
				end
				// older than the leaving entry loses one younger
				if (valid[i]) begin
					age[i] <= age[i] + age_w'(do_alloc)
						- age_w'(sel_found && age[i] > age[sel_idx]);
				end
			end
			// dispatch frees the slot
			if (sel_found) begin
				valid[sel_idx] <= 1'b0;
			end
			if (do_alloc) begin
				valid[free_idx] <= 1'b1;
				op[free_idx] <= alloc_op;
				dest[free_idx] <= alloc_tag;
				val_a[free_idx] <= opnd_a;
				val_b[free_idx] <= opnd_b;
				wait_a[free_idx] <= opnd_tag_a;
				wait_b[free_idx] <= opnd_tag_b;
				// a bus hit in the issue cycle is already in opnd
				rdy_a[free_idx] <= (opnd_src_a != src_bus) || (bus_valid && bus_tag == opnd_tag_a);
				rdy_b[free_idx] <= (opnd_src_b != src_bus) || (bus_valid && bus_tag == opnd_tag_b);
				age[free_idx] <= '0;
			end
		end
	end

endmodule

/* src/uarch_pkg.sv */
package uarch_pkg;

	// reorder buffer entry life cycle
	typedef enum logic [1:0] {
		rob_empty = 2'd0,
		rob_busy  = 2'd1,
		rob_done  = 2'd2
	} rob_state_e;

	// where issue found an operand
	// src_bus means the value comes off the result bus,
	// either in the issue cycle or later through wake-up
	typedef enum logic [1:0] {
		src_regfile = 2'd0,
		src_rob     = 2'd1,
		src_bus     = 2'd2
	} opnd_src_e;

endpackage

/* verif/tb_ooo_core.sv */
`timescale 1ns/1ps

module tb_ooo_core import isa_pkg::*; ();

	localparam int rob_depth = 8;
	localparam int rs_depth = 4;
	// instruction counts per test
	localparam int n_reset = 4;
	localparam int n_indep = 40;
	localparam int n_chain = 40;
	localparam int n_waw = 27;
	localparam int n_burst = 60;
	localparam int n_zero = 10;
	localparam int total_insts = n_reset + n_indep + n_chain + n_waw + n_burst + n_zero;
	localparam int cycle_limit = total_insts * (rob_depth + 4) + 200;

	logic                 clock;
	logic                 reset;
	logic                 inst_valid;
	alu_op_e              inst_op;
	logic [reg_idx_w-1:0] inst_rd;
	logic [reg_idx_w-1:0] inst_rs1;
	logic [reg_idx_w-1:0] inst_rs2;
	logic [xlen-1:0]      inst_imm;
	logic                 issue_stall;
	logic                 commit_valid;
	logic [reg_idx_w-1:0] commit_rd;
	logic [xlen-1:0]      commit_data;

	// in-order architectural model
	logic [xlen-1:0]      model_regs [32];
	logic [reg_idx_w-1:0] exp_rd [$];
	logic [xlen-1:0]      exp_data [$];
	logic [reg_idx_w-1:0] recent [3];

	int pass_count = 0;
	int fail_count = 0;
	int other_fails = 0;
	int commit_count = 0;
	int accepted = 0;
	int stall_cycles = 0;
	int fails_before = 0;
	int stalls_before = 0;
	int cycles = 0;
	int unsigned seed_dummy;
	logic [reg_idx_w-1:0] prev;
	logic [reg_idx_w-1:0] prev2;
	logic [reg_idx_w-1:0] rd_pick;

	ooo_core #(.rob_depth(rob_depth), .rs_depth(rs_depth)) dut (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	//////////////////////////////
	// reference model
	//////////////////////////////

	function automatic logic [xlen-1:0] model_result(alu_op_e op, logic [xlen-1:0] a,
		logic [xlen-1:0] b);
		case (op)
			op_add, op_addi: return a + b;
			op_sub:  return a - b;
			op_and:  return a & b;
			op_or:   return a | b;
			op_xor:  return a ^ b;
			// signed less-than gives 0 or 1
			op_slt:  return ($signed(a) < $signed(b)) ? xlen'(1) : xlen'(0);
			op_sll:  return a << b[4:0];
			default: return '0;
		endcase
	endfunction

	function automatic alu_op_e random_op();
		return alu_op_e'(3'($urandom_range(7, 0)));
	endfunction

	function automatic logic [reg_idx_w-1:0] reg_in_range(int lo, int hi);
		return reg_idx_w'($urandom_range(hi, lo));
	endfunction

	task automatic check_value(string name, logic [xlen-1:0] got, logic [xlen-1:0] exp);
		if (got !== exp) begin
			$display("ERR at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	//////////////////////////////
	// stimulus helpers
	//////////////////////////////

	// one instruction on a falling edge and held off while stalled
	task automatic send_inst(alu_op_e op, logic [reg_idx_w-1:0] rd,
		logic [reg_idx_w-1:0] rs1, logic [reg_idx_w-1:0] rs2, logic [xlen-1:0] imm);
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic [xlen-1:0] res;
		@(negedge clock);
		while (issue_stall) begin
			inst_valid = 1'b0;
			stall_cycles++;
			@(negedge clock);
		end
		inst_valid = 1'b1;
		inst_op = op;
		inst_rd = rd;
		inst_rs1 = rs1;
		inst_rs2 = rs2;
		inst_imm = imm;
		// accepted on the next rising edge
		a = model_regs[rs1];
		b = (op == op_addi) ? imm : model_regs[rs2];
		res = model_result(op, a, b);
		if (rd != '0) begin
			model_regs[rd] = res;
		end
		exp_rd.push_back(rd);
		exp_data.push_back(res);
		accepted++;
	endtask

	// stop issuing and wait until everything retired
	task automatic end_test(int num, string name);
		@(negedge clock);
		inst_valid = 1'b0;
		while (commit_count < accepted) begin
			@(negedge clock);
		end
		$display("test %0d (%s) finished with %0d failures", num, name,
			fail_count + other_fails - fails_before);
		fails_before = fail_count + other_fails;
	endtask

	//////////////////////////////
	// commit monitor
	//////////////////////////////

	always @(negedge clock) begin
		if (!reset && commit_valid) begin
			if (commit_count >= exp_rd.size()) begin
				$display("extra commit at %0t with no accepted instruction left", $time);
				fail_count++;
			end else begin
				check_value("commit_rd", xlen'(commit_rd), xlen'(exp_rd[commit_count]));
				check_value("commit_data", commit_data, exp_data[commit_count]);
			end
			commit_count++;
		end
	end

	// hang guard
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, %0d of %0d accepted instructions never committed",
				cycles, accepted - commit_count, accepted);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	//////////////////////////////
	// test sequence
	//////////////////////////////

	initial begin
		seed_dummy = $urandom(32'h98cd1c32);
		reset = 1'b1;
		inst_valid = 1'b0;
		inst_op = op_add;
		inst_rd = '0;
		inst_rs1 = '0;
		inst_rs2 = '0;
		inst_imm = '0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		repeat (8) @(negedge clock);
		reset = 1'b0;

		// quiet outputs right after reset and then addi from r0
		repeat (4) begin
			@(negedge clock);
			check_value("commit_valid", xlen'(commit_valid), '0);
			check_value("issue_stall", xlen'(issue_stall), '0);
		end
		for (int i = 1; i <= n_reset; i++) begin
			send_inst(op_addi, reg_idx_w'(i), '0, reg_in_range(0, 31), $urandom());
		end
		end_test(1, "reset and r0 addi");

		// sources never written here
		repeat (n_indep) begin
			send_inst(random_op(), reg_in_range(16, 31), reg_in_range(0, 15),
				reg_in_range(0, 15), $urandom());
		end
		end_test(2, "independent ops");

		// sources from the last three destinations
		recent[0] = 5'd1;
		recent[1] = 5'd2;
		recent[2] = 5'd3;
		repeat (n_chain) begin
			rd_pick = reg_in_range(1, 31);
			send_inst(random_op(), rd_pick, recent[2'($urandom_range(2, 0))],
				recent[2'($urandom_range(2, 0))], $urandom());
			recent[2] = recent[1];
			recent[1] = recent[0];
			recent[0] = rd_pick;
		end
		end_test(3, "dependent chains");

		// repeated writes to r5 and r6 and then a read of both
		repeat (3) begin
			repeat (4) begin
				send_inst(op_addi, 5'd5, reg_in_range(0, 31), '0, $urandom());
				send_inst(random_op(), 5'd6, reg_in_range(0, 31), reg_in_range(0, 31),
					$urandom());
			end
			send_inst(op_add, 5'd7, 5'd5, 5'd6, '0);
		end
		end_test(4, "write after write");

		// every op waits on the two before it
		stalls_before = stall_cycles;
		prev = 5'd9;
		prev2 = 5'd10;
		repeat (n_burst) begin
			rd_pick = reg_in_range(9, 14);
			send_inst(random_op(), rd_pick, prev, prev2, $urandom());
			prev2 = prev;
			prev = rd_pick;
		end
		if (stall_cycles == stalls_before) begin
			$display("issue_stall never rose during the back-pressure burst");
			other_fails++;
		end
		end_test(5, "back-pressure");

		// r0 as destination and later as source
		repeat (5) begin
			send_inst(random_op(), '0, reg_in_range(1, 31), reg_in_range(1, 31), $urandom());
		end
		repeat (5) begin
			send_inst(random_op(), reg_in_range(20, 31), '0, '0, $urandom());
		end
		end_test(6, "register zero");

		// late or duplicate commits
		repeat (20) @(negedge clock);
		if (commit_count != accepted) begin
			$display("%0d commits seen for %0d accepted instructions", commit_count, accepted);
			other_fails++;
		end
		$display("checks passed %0d, failed %0d", pass_count, fail_count + other_fails);
		if (fail_count + other_fails == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
